// ==== src/calc_pkg.sv ====
package calc_pkg;

  localparam int DATA_W           = 32;
  localparam int REG_ADDR_W       = 5;
  localparam int COMP_STAGES      = 4;
  localparam int MUL_RESULT_STAGE = 3;
  localparam int DIV_CYCLES       = DATA_W;

  // Derived widths
  localparam int SHAMT_W   = $clog2(DATA_W);
  localparam int DIV_CNT_W = $clog2(DIV_CYCLES);

  typedef enum logic [2:0]
  {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_mul,
    op_div
  } calc_op_e;

  // One instruction as handed over by the dispatcher
  typedef struct packed
  {
    logic                  v;
    calc_op_e              op;
    logic                  rd_w_v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [DATA_W-1:0]     rs1;
    logic [DATA_W-1:0]     rs2;
  } dispatch_pkt_t;

  // Completion stage entry, also the writeback packet
  typedef struct packed
  {
    logic                  rd_w_v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0]     rd_data;
  } wb_pkt_t;

endpackage

// ==== src/calc_top.sv ====
`timescale 1ns/1ps

module calc_top
  (input logic                        clk_i
  , input logic                       rst_i
  , input calc_pkg::dispatch_pkt_t    dispatch_pkt_i
  , output logic                      long_ready_o
  , output calc_pkg::wb_pkt_t         iwb_pkt_o
  );

  import calc_pkg::*;

  dispatch_pkt_t             reservation_n;
  dispatch_pkt_t             reservation_r;
  wb_pkt_t [COMP_STAGES-1:0] comp_stage_r;
  wb_pkt_t [COMP_STAGES:0]   comp_stage_n;
  logic [DATA_W-1:0]         int_data;
  logic                      int_v;
  logic [DATA_W-1:0]         mul_data;
  logic                      mul_v;
  wb_pkt_t                   long_pkt;
  logic                      long_v;
  logic                      long_yumi;

  operand_bypass u_operand_bypass
    (.dispatch_pkt_i(dispatch_pkt_i)
    , .comp_stage_r_i(comp_stage_r)
    , .comp_stage_n_i(comp_stage_n)
    , .reservation_n_o(reservation_n)
    );

  // Reservation register feeding all three pipes
  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (rst_i)
    begin
      reservation_r.v <= 1'b0;
    end
  end

  int_alu u_int_alu
    (.reservation_i(reservation_r)
    , .data_o(int_data)
    , .v_o(int_v)
    );

  mul_pipe u_mul_pipe
    (.clk_i(clk_i)
    , .rst_i(rst_i)
    , .reservation_i(reservation_r)
    , .data_o(mul_data)
    , .v_o(mul_v)
    );

  div_long_pipe u_div_long_pipe
    (.clk_i(clk_i)
    , .rst_i(rst_i)
    , .reservation_i(reservation_r)
    , .ready_o(long_ready_o)
    , .wb_pkt_o(long_pkt)
    , .v_o(long_v)
    , .yumi_i(long_yumi)
    );

  completion_pipe u_completion_pipe
    (.clk_i(clk_i)
    , .rst_i(rst_i)
    , .reservation_n_i(reservation_n)
    , .int_data_i(int_data)
    , .int_v_i(int_v)
    , .mul_data_i(mul_data)
    , .mul_v_i(mul_v)
    , .long_pkt_i(long_pkt)
    , .long_v_i(long_v)
    , .long_yumi_o(long_yumi)
    , .comp_stage_r_o(comp_stage_r)
    , .comp_stage_n_o(comp_stage_n)
    , .iwb_pkt_o(iwb_pkt_o)
    );

endmodule

// ==== src/completion_pipe.sv ====
`timescale 1ns/1ps

module completion_pipe
  (input logic                                             clk_i
  , input logic                                            rst_i
  , input calc_pkg::dispatch_pkt_t                         reservation_n_i
  , input logic [calc_pkg::DATA_W-1:0]                     int_data_i
  , input logic                                            int_v_i
  , input logic [calc_pkg::DATA_W-1:0]                     mul_data_i
  , input logic                                            mul_v_i
  , input calc_pkg::wb_pkt_t                               long_pkt_i
  , input logic                                            long_v_i
  , output logic                                           long_yumi_o
  , output calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0]  comp_stage_r_o
  , output calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES:0]    comp_stage_n_o
  , output calc_pkg::wb_pkt_t                              iwb_pkt_o
  );

  import calc_pkg::*;

  wb_pkt_t [COMP_STAGES-1:0] comp_stage_r;
  wb_pkt_t [COMP_STAGES:0]   comp_stage_n;

  always_comb
  begin
    // Divides write back through the long pipe instead
    comp_stage_n[0].rd_w_v  = reservation_n_i.v
                              & reservation_n_i.rd_w_v
                              & (reservation_n_i.op != op_div);
    comp_stage_n[0].rd_addr = reservation_n_i.rd_addr;
    comp_stage_n[0].rd_data = '0;

    for (int i = 1; i <= COMP_STAGES; i++)
    begin
      comp_stage_n[i] = comp_stage_r[i-1];
    end

    // Single issue with fixed latencies, so at most one pipe fills a stage
    comp_stage_n[1].rd_data                |= int_v_i ? int_data_i : '0;
    comp_stage_n[MUL_RESULT_STAGE].rd_data |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i)
  begin
    comp_stage_r <= comp_stage_n[COMP_STAGES-1:0];
    if (rst_i)
    begin
      for (int i = 0; i < COMP_STAGES; i++)
      begin
        comp_stage_r[i].rd_w_v <= 1'b0;
      end
    end
  end

  // Divide result takes the writeback port only when the last stage is not writing
  assign long_yumi_o = long_v_i & ~comp_stage_r[COMP_STAGES-1].rd_w_v;
  assign iwb_pkt_o   = long_yumi_o ? long_pkt_i : comp_stage_r[COMP_STAGES-1];

  assign comp_stage_r_o = comp_stage_r;
  assign comp_stage_n_o = comp_stage_n;

endmodule

// ==== src/div_long_pipe.sv ====
`timescale 1ns/1ps

module div_long_pipe
  (input logic                              clk_i
  , input logic                             rst_i
  , input calc_pkg::dispatch_pkt_t          reservation_i
  , output logic                            ready_o
  , output calc_pkg::wb_pkt_t               wb_pkt_o
  , output logic                            v_o
  , input logic                             yumi_i
  );

  import calc_pkg::*;

  typedef enum logic [1:0]
  {
    div_idle,
    div_busy,
    div_done
  } div_state_e;

  div_state_e            state_r;
  div_state_e            state_n;
  logic                  start;
  logic                  last_iter;
  logic [DIV_CNT_W-1:0]  cnt_r;
  logic [DATA_W-1:0]     divisor_r;
  logic [DATA_W-1:0]     quo_r;
  logic [DATA_W-1:0]     rem_r;
  logic [DATA_W:0]       rem_shift;
  logic [DATA_W:0]       rem_diff;
  logic                  rd_w_v_r;
  logic [REG_ADDR_W-1:0] rd_addr_r;

  assign start     = reservation_i.v & (reservation_i.op == op_div) & (state_r == div_idle);
  assign last_iter = (cnt_r == DIV_CNT_W'(DIV_CYCLES-1));

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      div_idle: state_n = start ? div_busy : div_idle;
      div_busy: state_n = last_iter ? div_done : div_busy;
      div_done: state_n = yumi_i ? div_idle : div_done;
      default:  state_n = div_idle;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_r <= div_idle;
      cnt_r   <= '0;
    end
    else
    begin
      state_r <= state_n;
      if (start)
        cnt_r <= '0;
      else if (state_r == div_busy)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // Dividend shifts out of the quotient register MSB first
  assign rem_shift = {rem_r, quo_r[DATA_W-1]};
  assign rem_diff  = rem_shift - {1'b0, divisor_r};

  // A zero divisor never borrows, so the quotient fills with ones
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      quo_r     <= reservation_i.rs1;
      divisor_r <= reservation_i.rs2;
      rem_r     <= '0;
      rd_w_v_r  <= reservation_i.rd_w_v;
      rd_addr_r <= reservation_i.rd_addr;
    end
    else if (state_r == div_busy)
    begin
      if (rem_diff[DATA_W])
      begin
        rem_r <= rem_shift[DATA_W-1:0];
        quo_r <= {quo_r[DATA_W-2:0], 1'b0};
      end
      else
      begin
        rem_r <= rem_diff[DATA_W-1:0];
        quo_r <= {quo_r[DATA_W-2:0], 1'b1};
      end
    end
  end

  assign ready_o  = (state_r == div_idle);
  assign v_o      = (state_r == div_done);
  assign wb_pkt_o = '{rd_w_v: rd_w_v_r, rd_addr: rd_addr_r, rd_data: quo_r};

endmodule

// ==== src/int_alu.sv ====
`timescale 1ns/1ps

module int_alu
  (input calc_pkg::dispatch_pkt_t           reservation_i
  , output logic [calc_pkg::DATA_W-1:0]     data_o
  , output logic                            v_o
  );

  import calc_pkg::*;

  logic alu_op;

  always_comb
  begin
    alu_op = 1'b1;
    case (reservation_i.op)
      op_add: data_o = reservation_i.rs1 + reservation_i.rs2;
      op_sub: data_o = reservation_i.rs1 - reservation_i.rs2;
      op_and: data_o = reservation_i.rs1 & reservation_i.rs2;
      op_or:  data_o = reservation_i.rs1 | reservation_i.rs2;
      op_xor: data_o = reservation_i.rs1 ^ reservation_i.rs2;
      op_sll: data_o = reservation_i.rs1 << reservation_i.rs2[SHAMT_W-1:0];
      default:
      begin
        // Multiply and divide belong to the other pipes
        data_o = '0;
        alu_op = 1'b0;
      end
    endcase
  end

  assign v_o = reservation_i.v & alu_op;

endmodule

// ==== src/mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe
  (input logic                              clk_i
  , input logic                             rst_i
  , input calc_pkg::dispatch_pkt_t          reservation_i
  , output logic [calc_pkg::DATA_W-1:0]     data_o
  , output logic                            v_o
  );

  import calc_pkg::*;

  logic                mul_start;
  logic [1:0]          v_r;
  logic [DATA_W-1:0]   op_a_r;
  logic [DATA_W-1:0]   op_b_r;
  logic [DATA_W-1:0]   prod_low;
  logic [DATA_W-1:0]   prod_r;

  assign mul_start = reservation_i.v & (reservation_i.op == op_mul);

  // Valid tags follow the operands and then the product
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r <= {v_r[0], mul_start};
    end
  end

  // Only the low half of the product is written back
  assign prod_low = op_a_r * op_b_r;

  always_ff @(posedge clk_i)
  begin
    op_a_r <= reservation_i.rs1;
    op_b_r <= reservation_i.rs2;
    prod_r <= prod_low;
  end

  // Lands in completion stage 3 at the following edge
  assign data_o = prod_r;
  assign v_o    = v_r[1];

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass
  (input calc_pkg::dispatch_pkt_t                          dispatch_pkt_i
  , input calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES-1:0]   comp_stage_r_i
  , input calc_pkg::wb_pkt_t [calc_pkg::COMP_STAGES:0]     comp_stage_n_i
  , output calc_pkg::dispatch_pkt_t                        reservation_n_o
  );

  import calc_pkg::*;

  logic [COMP_STAGES-1:0] match_rs1;
  logic [COMP_STAGES-1:0] match_rs2;

  // A stage holding a pending write to a source register
  for (genvar i = 0; i < COMP_STAGES; i++)
  begin : g_match
    assign match_rs1[i] = dispatch_pkt_i.v
                          & comp_stage_r_i[i].rd_w_v
                          & (dispatch_pkt_i.rs1_addr == comp_stage_r_i[i].rd_addr);
    assign match_rs2[i] = dispatch_pkt_i.v
                          & comp_stage_r_i[i].rd_w_v
                          & (dispatch_pkt_i.rs2_addr == comp_stage_r_i[i].rd_addr);
  end

  // Walk from the oldest stage up so the youngest match is applied last
  always_comb
  begin
    reservation_n_o = dispatch_pkt_i;
    for (int i = COMP_STAGES-1; i >= 0; i--)
    begin
      // Stage i moves to i+1 at the edge, so its next-state data is current
      if (match_rs1[i])
      begin
        reservation_n_o.rs1 = comp_stage_n_i[i+1].rd_data;
      end
      if (match_rs2[i])
      begin
        reservation_n_o.rs2 = comp_stage_n_i[i+1].rd_data;
      end
    end
  end

endmodule

// ==== tb.f ====
src/calc_pkg.sv
src/operand_bypass.sv
src/int_alu.sv
src/mul_pipe.sv
src/div_long_pipe.sv
src/completion_pipe.sv
src/calc_top.sv
tests/calc_tb.sv

// ==== tests/calc_tb.sv ====
`timescale 1ns/1ps

module calc_tb;

  import calc_pkg::*;

  localparam int NUM_REGS = 2**REG_ADDR_W;

  logic          clk;
  logic          rst;
  dispatch_pkt_t dispatch_pkt;
  logic          long_ready;
  wb_pkt_t       iwb_pkt;

  // Register file seen by the dispatcher, and program-order results
  logic [DATA_W-1:0]     ref_regs [NUM_REGS];
  logic [DATA_W-1:0]     golden [NUM_REGS];
  logic [REG_ADDR_W-1:0] exp_rd_q [$];
  logic [DATA_W-1:0]     exp_data_q [$];
  int                    exp_due_q [$];
  logic [15:0]           lfsr_state;
  int                    cyc = 0;
  int                    checks = 0;
  int                    errors = 0;

  calc_top u_calc_top
    (.clk_i(clk)
    , .rst_i(rst)
    , .dispatch_pkt_i(dispatch_pkt)
    , .long_ready_o(long_ready)
    , .iwb_pkt_o(iwb_pkt)
    );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Taps 16, 14, 13, 11
  function automatic logic [DATA_W-1:0] lfsr_bits(input int n);
    logic [DATA_W-1:0] bits;
    logic              fb;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits       = {bits[DATA_W-2:0], fb};
    end
    return bits;
  endfunction

  function automatic logic [DATA_W-1:0] expected_result(input calc_op_e op,
    input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    case (op)
      op_add: return a + b;
      op_sub: return a - b;
      op_and: return a & b;
      op_or:  return a | b;
      op_xor: return a ^ b;
      op_sll: return a << b[4:0];
      op_mul: return a * b;
      default: return (b == '0) ? '1 : a / b;
    endcase
  endfunction

  function automatic calc_op_e random_alu_op();
    return calc_op_e'(lfsr_bits(3) % 6);
  endfunction

  function automatic int random_traffic_src();
    return lfsr_bits(1) ? 5 + int'(lfsr_bits(1)) : 20 + int'(lfsr_bits(2));
  endfunction

  function automatic bit rd_pending(input int rd);
    bit pending;
    pending = 1'b0;
    foreach (exp_rd_q[i])
      if (exp_rd_q[i] == rd) pending = 1'b1;
    return pending;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic idle_cycle();
    dispatch_pkt.v = 1'b0;
    next_cycle();
  endtask

  // Operands come from the possibly stale register file
  task automatic dispatch(input calc_op_e op, input int rd, input int rs1, input int rs2);
    logic [DATA_W-1:0] result;
    result                = expected_result(op, golden[rs1], golden[rs2]);
    dispatch_pkt.v        = 1'b1;
    dispatch_pkt.op       = op;
    dispatch_pkt.rd_w_v   = (rd != 0);
    dispatch_pkt.rd_addr  = REG_ADDR_W'(rd);
    dispatch_pkt.rs1_addr = REG_ADDR_W'(rs1);
    dispatch_pkt.rs2_addr = REG_ADDR_W'(rs2);
    dispatch_pkt.rs1      = ref_regs[rs1];
    dispatch_pkt.rs2      = ref_regs[rs2];
    if (rd != 0)
    begin
      golden[rd] = result;
      exp_rd_q.push_back(REG_ADDR_W'(rd));
      exp_data_q.push_back(result);
      exp_due_q.push_back((op == op_div) ? -1 : cyc + 4);
    end
    next_cycle();
  endtask

  task automatic compare_writeback(input wb_pkt_t wb);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_rd_q.size(); i++)
      if (idx < 0 && exp_rd_q[i] == wb.rd_addr) idx = i;
    checks++;
    if (idx < 0)
    begin
      errors++;
      $display("Unexpected writeback to r%0d at time %0t", wb.rd_addr, $time);
    end
    else
    begin
      if (wb.rd_data !== exp_data_q[idx])
      begin
        errors++;
        $display("[FAIL] %0t: r%0d written %h, expected %h", $time, wb.rd_addr,
                 wb.rd_data, exp_data_q[idx]);
      end
      if (exp_due_q[idx] >= 0 && exp_due_q[idx] != cyc)
      begin
        errors++;
        $display("[FAIL] %0t: r%0d written in cycle %0d, expected cycle %0d", $time,
                 wb.rd_addr, cyc, exp_due_q[idx]);
      end
      exp_rd_q.delete(idx);
      exp_data_q.delete(idx);
      exp_due_q.delete(idx);
    end
    ref_regs[wb.rd_addr] = wb.rd_data;
  endtask

  // Writeback port is stable in the middle of the cycle
  always @(negedge clk)
  begin
    if (!rst && iwb_pkt.rd_w_v)
      compare_writeback(iwb_pkt);
  end

  task automatic wait_long_ready();
    int n;
    n = 0;
    while (!long_ready && n < 200)
    begin
      idle_cycle();
      n++;
    end
    if (!long_ready)
    begin
      errors++;
      $display("Timed out waiting for long_ready_o at time %0t", $time);
    end
  endtask

  task automatic wait_for_rd_writeback(input int rd);
    int n;
    n = 0;
    while (rd_pending(rd) && n < 300)
    begin
      idle_cycle();
      n++;
    end
    if (rd_pending(rd))
    begin
      errors++;
      $display("Timed out waiting for the divide writeback to r%0d at time %0t", rd, $time);
    end
  endtask

  task automatic drain_writebacks();
    int n;
    n = 0;
    while (exp_rd_q.size() != 0 && n < 300)
    begin
      idle_cycle();
      n++;
    end
    if (exp_rd_q.size() != 0)
    begin
      errors++;
      $display("Timed out with %0d writebacks still missing", exp_rd_q.size());
    end
  endtask

  task automatic check_reset_idle();
    for (int i = 0; i < 5; i++)
    begin
      checks++;
      if (iwb_pkt.rd_w_v !== 1'b0 || long_ready !== 1'b1)
      begin
        errors++;
        $display("[FAIL] %0t: after reset rd_w_v=%b long_ready_o=%b", $time,
                 iwb_pkt.rd_w_v, long_ready);
      end
      idle_cycle();
    end
  endtask

  task automatic alu_independent();
    for (int i = 0; i < 12; i++)
      dispatch(random_alu_op(), 1 + (i % 8), 16 + int'(lfsr_bits(3)), 16 + int'(lfsr_bits(3)));
    drain_writebacks();
  endtask

  // Writers rotate over r1..r4 so sources sit in every completion stage
  task automatic alu_forwarding_chains();
    for (int i = 0; i < 24; i++)
      dispatch(random_alu_op(), 1 + (i % 4), 1 + ((i + 3) % 4), 1 + ((i + i / 4) % 4));
    drain_writebacks();
  endtask

  task automatic multiply_mix();
    dispatch(op_mul, 9, 16, 17);
    dispatch(op_add, 10, 18, 19);
    dispatch(op_xor, 11, 10, 20);
    dispatch(op_mul, 12, 9, 11);
    dispatch(op_and, 13, 9, 10);
    dispatch(op_mul, 14, 28, 29);
    dispatch(op_or, 15, 12, 13);
    dispatch(op_sub, 10, 15, 13);
    dispatch(op_add, 11, 14, 12);
    dispatch(op_mul, 9, 11, 11);
    dispatch(op_mul, 12, 10, 13);
    drain_writebacks();
  endtask

  task automatic divide_with_traffic();
    int dividend [4] = '{16, 17, 1, 5};
    int divisor [4]  = '{28, 0, 29, 30};
    for (int j = 0; j < 4; j++)
    begin
      wait_long_ready();
      dispatch(op_div, 24 + j, dividend[j], divisor[j]);
      dispatch(op_add, 5, 20, 21);
      checks++;
      if (long_ready !== 1'b0)
      begin
        errors++;
        $display("[FAIL] %0t: long_ready_o still high with a divide in flight", $time);
      end
      // Keeps the last stage busy past the divide's end
      for (int i = 0; i < 40; i++)
        dispatch(random_alu_op(), 5 + (i % 3), random_traffic_src(), random_traffic_src());
      idle_cycle();
      wait_for_rd_writeback(24 + j);
    end
    drain_writebacks();
    wait_long_ready();
  endtask

  initial
  begin
    lfsr_state   = 16'd59;
    rst          = 1'b1;
    dispatch_pkt = '0;
    ref_regs[0]  = '0;
    golden[0]    = '0;
    // Small values in r28..r31 serve as divisors
    for (int i = 1; i < NUM_REGS; i++)
    begin
      ref_regs[i] = (i >= 28) ? lfsr_bits(8) : lfsr_bits(DATA_W);
      golden[i]   = ref_regs[i];
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    check_reset_idle();
    alu_independent();
    alu_forwarding_chains();
    multiply_mix();
    divide_with_traffic();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
